/* dv/reg_manage_tb.sv */
`timescale 1ns/100ps

`include "reg_manage_defs.svh"

module reg_manage_tb;

    localparam int WAIT_LIMIT    = 20;
    localparam int RANDOM_CYCLES = 400;

    // one decode request as the testbench sees it
    typedef struct packed {
        logic                      rs1_order;
        reg_manage_pkg::reg_addr_t rs1_addr;
        logic                      rs2_order;
        reg_manage_pkg::reg_addr_t rs2_addr;
        logic                      rd_order;
        reg_manage_pkg::reg_addr_t rd_addr;
        reg_manage_pkg::context_t  ctx;
    } req_t;

    logic                      clk;
    logic                      arst_n;
    logic                      rs1_order;
    reg_manage_pkg::reg_addr_t rs1_addr;
    logic                      rs2_order;
    reg_manage_pkg::reg_addr_t rs2_addr;
    logic                      rd_order;
    reg_manage_pkg::reg_addr_t rd_addr;
    reg_manage_pkg::context_t  req_ctx;
    logic                      wb_valid;
    reg_manage_pkg::reg_addr_t wb_addr;
    reg_manage_pkg::word_t     wb_data;
    logic                      branch_hazard;
    reg_manage_pkg::context_t  hazard_ctx;
    reg_manage_pkg::word_t     op1;
    reg_manage_pkg::word_t     op2;
    logic                      issue;
    logic                      killed;
    reg_manage_pkg::word_t     lr_data;

    // reference state
    reg_manage_pkg::word_t    model_regs [`NUM_REGS];
    reg_manage_pkg::pending_t model_pend [`NUM_REGS];

    int checks;
    int errors;
    int test_base;
    int seed_init;

    reg_manage UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .rs1_order     (rs1_order),
        .rs1_addr      (rs1_addr),
        .rs2_order     (rs2_order),
        .rs2_addr      (rs2_addr),
        .rd_order      (rd_order),
        .rd_addr       (rd_addr),
        .req_ctx       (req_ctx),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .op1           (op1),
        .op2           (op2),
        .issue         (issue),
        .killed        (killed),
        .lr_data       (lr_data)
    );

    always #20 clk = ~clk;

    task check_word(input string what, input reg_manage_pkg::word_t got,
                    input reg_manage_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function req_t make_req(input logic o1, input reg_manage_pkg::reg_addr_t a1,
                            input logic o2, input reg_manage_pkg::reg_addr_t a2,
                            input logic od, input reg_manage_pkg::reg_addr_t ad,
                            input reg_manage_pkg::context_t c);
        req_t r;
        r.rs1_order = o1;
        r.rs1_addr  = a1;
        r.rs2_order = o2;
        r.rs2_addr  = a2;
        r.rd_order  = od;
        r.rd_addr   = ad;
        r.ctx       = c;
        return r;
    endfunction

    // small address range so requests collide often
    function req_t random_req();
        req_t r;
        int   k;
        r.rs1_order = ($urandom_range(0, 1) == 1);
        r.rs1_addr  = reg_manage_pkg::reg_addr_t'($urandom_range(0, 7));
        r.rs2_order = ($urandom_range(0, 1) == 1);
        r.rs2_addr  = reg_manage_pkg::reg_addr_t'($urandom_range(0, 7));
        r.rd_order  = ($urandom_range(0, 1) == 1);
        r.rd_addr   = reg_manage_pkg::reg_addr_t'($urandom_range(0, 7));
        k = $urandom_range(0, 4);
        r.ctx = (k == 4) ? 4'b0000 : (4'b0001 << k);
        return r;
    endfunction

    // entry after write-back clear and hazard flush
    function reg_manage_pkg::pending_t next_entry(input int i);
        reg_manage_pkg::pending_t e;
        e = model_pend[i];
        if (wb_valid && (wb_addr == reg_manage_pkg::reg_addr_t'(i))) begin
            e = '0;
        end
        if (branch_hazard && (|(hazard_ctx & e.ctx))) begin
            e = '0;
        end
        if (i == 0) begin
            e = '0;
        end
        return e;
    endfunction

    function reg_manage_pkg::word_t read_src(input reg_manage_pkg::reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        if (wb_valid && (wb_addr == a)) begin
            return wb_data;
        end
        return model_regs[a];
    endfunction

    task next_edge;
        @(posedge clk);
        #2;
    endtask

    // sample outputs mid-cycle, then advance the model to the next edge
    task check_cycle;
        reg_manage_pkg::pending_t nxt [`NUM_REGS];
        logic any_order;
        logic hit;
        logic ready;
        logic exp_issue;
        #10;
        for (int i = 0; i < `NUM_REGS; i++) begin
            nxt[i] = next_entry(i);
        end
        any_order = rs1_order || rs2_order || rd_order;
        hit       = branch_hazard && (|(hazard_ctx & req_ctx));
        ready     = (!rs1_order || !nxt[rs1_addr].busy) &&
                    (!rs2_order || !nxt[rs2_addr].busy) &&
                    (!rd_order || !nxt[rd_addr].busy);
        exp_issue = any_order && !hit && ready;
        check_word("op1", op1, read_src(rs1_addr));
        check_word("op2", op2, read_src(rs2_addr));
        check_word("lr_data", lr_data, model_regs[`LINK_REG]);
        check_flag("issue", issue, exp_issue);
        check_flag("killed", killed, any_order && hit);
        if (wb_valid && (wb_addr != '0)) begin
            model_regs[wb_addr] = wb_data;
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_pend[i] = nxt[i];
        end
        if (exp_issue && rd_order && (rd_addr != '0)) begin
            model_pend[rd_addr] = '{busy: 1'b1, ctx: req_ctx};
        end
    endtask

    task run_cycle(input req_t r, input logic wv, input reg_manage_pkg::reg_addr_t wa,
                   input reg_manage_pkg::word_t wd, input logic hv,
                   input reg_manage_pkg::context_t hc);
        next_edge();
        rs1_order     = r.rs1_order;
        rs1_addr      = r.rs1_addr;
        rs2_order     = r.rs2_order;
        rs2_addr      = r.rs2_addr;
        rd_order      = r.rd_order;
        rd_addr       = r.rd_addr;
        req_ctx       = r.ctx;
        wb_valid      = wv;
        wb_addr       = wa;
        wb_data       = wd;
        branch_hazard = hv;
        hazard_ctx    = hc;
        check_cycle();
    endtask

    // hold a request until issue, write-back arrives on cycle wb_at
    task hold_until_issue(input req_t r, input int wb_at,
                          input reg_manage_pkg::reg_addr_t wa,
                          input reg_manage_pkg::word_t wd, output int cycles);
        int n;
        n = 0;
        cycles = -1;
        while ((cycles < 0) && (n < WAIT_LIMIT)) begin
            run_cycle(r, n == wb_at, wa, wd, 1'b0, 4'b0000);
            if (issue) begin
                cycles = n;
            end
            n++;
        end
        if (cycles < 0) begin
            errors++;
            $display("timeout: request was not issued within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        int   cycles;
        req_t cur;
        clk           = 1'b0;
        arst_n        = 1'b0;
        rs1_order     = 1'b0;
        rs1_addr      = '0;
        rs2_order     = 1'b0;
        rs2_addr      = '0;
        rd_order      = 1'b0;
        rd_addr       = '0;
        req_ctx       = '0;
        wb_valid      = 1'b0;
        wb_addr       = '0;
        wb_data       = '0;
        branch_hazard = 1'b0;
        hazard_ctx    = '0;
        checks        = 0;
        errors        = 0;
        test_base     = 0;
        seed_init     = $urandom(32'h9261);
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
            model_pend[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // fresh state issues at once
        run_cycle(make_req(1'b1, 5'd3, 1'b1, 5'd5, 1'b1, 5'd7, 4'b0001),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        check_flag("issue after reset", issue, 1'b1);
        check_word("op1 after reset", op1, 32'h0);
        check_word("op2 after reset", op2, 32'h0);
        check_word("lr_data after reset", lr_data, 32'h0);
        end_test("reset_issue");

        // read of pending r7, then write of pending r9
        hold_until_issue(make_req(1'b1, 5'd7, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0010),
                         3, 5'd7, 32'h1111_0007, cycles);
        check_flag("read held until write-back", cycles == 3, 1'b1);
        run_cycle(make_req(1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd9, 4'b0001),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        check_flag("first write of r9", issue, 1'b1);
        hold_until_issue(make_req(1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd9, 4'b0001),
                         2, 5'd9, 32'h2222_0009, cycles);
        check_flag("write held until write-back", cycles == 2, 1'b1);
        run_cycle('0, 1'b1, 5'd9, 32'h3333_0009, 1'b0, 4'b0000);
        end_test("pending_hold");

        // same-cycle write-back forwarded, then read from the file
        run_cycle(make_req(1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd12, 4'b0001),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        run_cycle(make_req(1'b0, 5'd0, 1'b1, 5'd12, 1'b0, 5'd0, 4'b0001),
                  1'b1, 5'd12, 32'hcafe_0012, 1'b0, 4'b0000);
        check_flag("issue with forwarding", issue, 1'b1);
        check_word("forwarded op2", op2, 32'hcafe_0012);
        run_cycle(make_req(1'b1, 5'd12, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0001),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        check_flag("issue after write-back", issue, 1'b1);
        check_word("op1 from register file", op1, 32'hcafe_0012);
        end_test("forwarding");

        // r20 under level 2, r21 under level 3
        run_cycle(make_req(1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd20, 4'b0100),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        run_cycle(make_req(1'b0, 5'd0, 1'b0, 5'd0, 1'b1, 5'd21, 4'b1000),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        run_cycle(make_req(1'b1, 5'd20, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0100),
                  1'b0, 5'd0, 32'h0, 1'b1, 4'b0100);
        check_flag("killed on hazard", killed, 1'b1);
        check_flag("no issue on hazard", issue, 1'b0);
        run_cycle(make_req(1'b1, 5'd20, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0001),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        check_flag("flushed r20 free", issue, 1'b1);
        run_cycle(make_req(1'b1, 5'd21, 1'b0, 5'd0, 1'b0, 5'd0, 4'b0001),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        check_flag("r21 still pending", issue, 1'b0);
        run_cycle('0, 1'b1, 5'd21, 32'h4444_0021, 1'b0, 4'b0000);
        end_test("hazard_flush");

        // link register and the zero register
        run_cycle('0, 1'b1, `LINK_REG, 32'habcd_0001, 1'b0, 4'b0000);
        run_cycle('0, 1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        check_word("lr_data after write", lr_data, 32'habcd_0001);
        run_cycle('0, 1'b1, 5'd0, 32'hdead_beef, 1'b0, 4'b0000);
        run_cycle(make_req(1'b1, 5'd0, 1'b1, 5'd0, 1'b0, 5'd0, 4'b0000),
                  1'b0, 5'd0, 32'h0, 1'b0, 4'b0000);
        check_word("r0 on op1", op1, 32'h0);
        check_word("r0 on op2", op2, 32'h0);
        end_test("link_and_zero");

        // decode holds each request until issued or killed
        // an empty request is replaced right away
        cur = random_req();
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            run_cycle(cur, ($urandom_range(0, 1) == 1),
                      reg_manage_pkg::reg_addr_t'($urandom_range(0, 7)),
                      $urandom(), ($urandom_range(0, 7) == 0),
                      reg_manage_pkg::context_t'($urandom_range(1, 15)));
            if (issue || killed ||
                !(cur.rs1_order || cur.rs2_order || cur.rd_order)) begin
                cur = random_req();
            end
        end
        end_test("random");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* hdl/issue_check.sv */
`timescale 1ns/100ps

module issue_check (
    issue_req_if.sink                 req,
    input  reg_manage_pkg::word_t     rs1_data,
    input  reg_manage_pkg::word_t     rs2_data,
    input  logic                      wb_valid,
    input  reg_manage_pkg::reg_addr_t wb_addr,
    input  reg_manage_pkg::word_t     wb_data,
    input  logic                      rs1_busy,
    input  logic                      rs2_busy,
    input  logic                      rd_busy,
    input  logic                      branch_hazard,
    input  reg_manage_pkg::context_t  hazard_ctx,
    output reg_manage_pkg::word_t     op1,
    output reg_manage_pkg::word_t     op2,
    output logic                      issue,
    output logic                      killed,
    output logic                      set_valid
);

    logic fwd_rs1;
    logic fwd_rs2;
    logic any_order;
    logic hazard_hit;
    logic rs1_ready;
    logic rs2_ready;
    logic rd_ready;

    // write-back of this cycle bypasses the register file
    assign fwd_rs1 = wb_valid && (wb_addr == req.rs1_addr) && (req.rs1_addr != '0);
    assign fwd_rs2 = wb_valid && (wb_addr == req.rs2_addr) && (req.rs2_addr != '0);

    assign op1 = fwd_rs1 ? wb_data : rs1_data;
    assign op2 = fwd_rs2 ? wb_data : rs2_data;

    assign any_order = req.rs1_order || req.rs2_order || req.rd_order;

    // request sits under a branch that just resolved wrong
    assign hazard_hit = branch_hazard && (|(hazard_ctx & req.ctx));
    assign killed     = hazard_hit && any_order;

    // an unordered operand never blocks
    assign rs1_ready = !req.rs1_order || !rs1_busy;
    assign rs2_ready = !req.rs2_order || !rs2_busy;
    assign rd_ready  = !req.rd_order  || !rd_busy;

    assign issue = any_order && !hazard_hit && rs1_ready && rs2_ready && rd_ready;

    // destination becomes pending only when it is actually written
    assign set_valid = issue && req.rd_order;

endmodule

/* hdl/issue_req_if.sv */
`timescale 1ns/100ps

interface issue_req_if;

    // source operands
    logic                      rs1_order;
    reg_manage_pkg::reg_addr_t rs1_addr;
    logic                      rs2_order;
    reg_manage_pkg::reg_addr_t rs2_addr;

    // destination
    logic                      rd_order;
    reg_manage_pkg::reg_addr_t rd_addr;

    // speculation context of the request
    reg_manage_pkg::context_t  ctx;

    modport source (
        output rs1_order, rs1_addr,
        output rs2_order, rs2_addr,
        output rd_order, rd_addr,
        output ctx
    );

    modport sink (
        input rs1_order, rs1_addr,
        input rs2_order, rs2_addr,
        input rd_order, rd_addr,
        input ctx
    );

endinterface

/* hdl/pending_table.sv */
`timescale 1ns/100ps

`include "reg_manage_defs.svh"

module pending_table (
    input  logic                      clk,
    input  logic                      arst_n,
    issue_req_if.sink                 req,
    input  logic                      wb_valid,
    input  reg_manage_pkg::reg_addr_t wb_addr,
    input  logic                      branch_hazard,
    input  reg_manage_pkg::context_t  hazard_ctx,
    input  logic                      set_valid,
    output logic                      rs1_busy,
    output logic                      rs2_busy,
    output logic                      rd_busy
);

    reg_manage_pkg::pending_t table_q    [`NUM_REGS];
    reg_manage_pkg::pending_t table_next [`NUM_REGS];

    // next view of every entry
    // write-back clear first, then hazard flush
    always_comb begin
        for (int i = 0; i < `NUM_REGS; i++) begin
            table_next[i] = table_q[i];
            if (wb_valid && (wb_addr == reg_manage_pkg::reg_addr_t'(i))) begin
                table_next[i] = reg_manage_pkg::PENDING_FREE;
            end
            if (branch_hazard && (|(hazard_ctx & table_next[i].ctx))) begin
                table_next[i] = reg_manage_pkg::PENDING_FREE;
            end
        end
        // zero register never waits on anything
        table_next[0] = reg_manage_pkg::PENDING_FREE;
    end

    // lookups see same-cycle clears and flushes
    assign rs1_busy = table_next[req.rs1_addr].busy;
    assign rs2_busy = table_next[req.rs2_addr].busy;
    assign rd_busy  = table_next[req.rd_addr].busy;

    // issue set lands last, on top of the next view
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                table_q[i] <= reg_manage_pkg::PENDING_FREE;
            end
        end else begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                table_q[i] <= table_next[i];
            end
            if (set_valid && (req.rd_addr != '0)) begin
                table_q[req.rd_addr] <= '{busy: 1'b1, ctx: req.ctx};
            end
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/100ps

`include "reg_manage_defs.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  reg_manage_pkg::reg_addr_t rs1_addr,
    input  reg_manage_pkg::reg_addr_t rs2_addr,
    output reg_manage_pkg::word_t     rs1_data,
    output reg_manage_pkg::word_t     rs2_data,
    output reg_manage_pkg::word_t     lr_data,
    input  logic                      wb_valid,
    input  reg_manage_pkg::reg_addr_t wb_addr,
    input  reg_manage_pkg::word_t     wb_data
);

    // register 0 has no storage
    reg_manage_pkg::word_t regs [`NUM_REGS-1:1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // combinational reads, zero register reads as zero
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

    // fixed link register port
    assign lr_data = regs[`LINK_REG];

endmodule

/* hdl/reg_manage.sv */
`timescale 1ns/100ps

module reg_manage (
    input  logic                      clk,
    input  logic                      arst_n,

    // decode request
    input  logic                      rs1_order,
    input  reg_manage_pkg::reg_addr_t rs1_addr,
    input  logic                      rs2_order,
    input  reg_manage_pkg::reg_addr_t rs2_addr,
    input  logic                      rd_order,
    input  reg_manage_pkg::reg_addr_t rd_addr,
    input  reg_manage_pkg::context_t  req_ctx,

    // write-back
    input  logic                      wb_valid,
    input  reg_manage_pkg::reg_addr_t wb_addr,
    input  reg_manage_pkg::word_t     wb_data,

    // branch resolution
    input  logic                      branch_hazard,
    input  reg_manage_pkg::context_t  hazard_ctx,

    // to execute
    output reg_manage_pkg::word_t     op1,
    output reg_manage_pkg::word_t     op2,
    output logic                      issue,
    output logic                      killed,
    output reg_manage_pkg::word_t     lr_data
);

    reg_manage_pkg::word_t rs1_data;
    reg_manage_pkg::word_t rs2_data;
    logic                  rs1_busy;
    logic                  rs2_busy;
    logic                  rd_busy;
    logic                  set_valid;

    issue_req_if req ();

    // request bundle from the plain ports
    assign req.rs1_order = rs1_order;
    assign req.rs1_addr  = rs1_addr;
    assign req.rs2_order = rs2_order;
    assign req.rs2_addr  = rs2_addr;
    assign req.rd_order  = rd_order;
    assign req.rd_addr   = rd_addr;
    assign req.ctx       = req_ctx;

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .lr_data  (lr_data),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    pending_table u_pending_table (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req.sink),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .set_valid     (set_valid),
        .rs1_busy      (rs1_busy),
        .rs2_busy      (rs2_busy),
        .rd_busy       (rd_busy)
    );

    issue_check u_issue_check (
        .req           (req.sink),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .rs1_busy      (rs1_busy),
        .rs2_busy      (rs2_busy),
        .rd_busy       (rd_busy),
        .branch_hazard (branch_hazard),
        .hazard_ctx    (hazard_ctx),
        .op1           (op1),
        .op2           (op2),
        .issue         (issue),
        .killed        (killed),
        .set_valid     (set_valid)
    );

endmodule

/* hdl/reg_manage_defs.svh */
`ifndef REG_MANAGE_DEFS_SVH
`define REG_MANAGE_DEFS_SVH

// data word width
`define LEN_WORD 32

// register address width, register 0 is hard zero
`define LEN_REG_ADDR 5

// number of architectural registers
`define NUM_REGS (1 << `LEN_REG_ADDR)

// one bit per unresolved branch level
`define LEN_CONTEXT 4

// link register index
`define LINK_REG 1

`endif

/* hdl/reg_manage_pkg.sv */
package reg_manage_pkg;

`include "reg_manage_defs.svh"

    // one data word
    typedef logic [`LEN_WORD-1:0] word_t;

    // register address, same for virtual and physical
    typedef logic [`LEN_REG_ADDR-1:0] reg_addr_t;

    // one-hot mask of branch levels an instruction depends on
    typedef logic [`LEN_CONTEXT-1:0] context_t;

    // pending-table entry
    // ctx is the context of the instruction that owns the register
    typedef struct packed {
        logic     busy;
        context_t ctx;
    } pending_t;

    // entry value for a register with no result outstanding
    localparam pending_t PENDING_FREE = '{
        busy: 1'b0,
        ctx:  '0
    };

endpackage

/* reg_manage.f */
+incdir+hdl
hdl/reg_manage_pkg.sv
hdl/issue_req_if.sv
hdl/reg_file.sv
hdl/pending_table.sv
hdl/issue_check.sv
hdl/reg_manage.sv
dv/reg_manage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the reg_manage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=sim_reg_manage

verilator --binary --timing \
    -f reg_manage.f \
    --top-module reg_manage_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
